//--- mic_config.svh
`ifndef MIC_CONFIG_SVH
`define MIC_CONFIG_SVH

// Microphone array and I2S framing
`define MIC_CHANNELS     4      // Mono mics sharing sck and ws
`define MIC_SCK_HALF     4      // clk_in cycles per sck half period
`define MIC_SLOT_BITS    32     // Bit clocks per I2S slot
`define MIC_SAMPLE_BITS  24     // Valid bits in the left slot, MSB first

// Low-pass FIR taps, symmetric, sum 92
`define FIR_TAPS         8
`define FIR_COEF_0       8'sd2
`define FIR_COEF_1       8'sd6
`define FIR_COEF_2       8'sd14
`define FIR_COEF_3       8'sd24
`define FIR_COEF_4       8'sd24
`define FIR_COEF_5       8'sd14
`define FIR_COEF_6       8'sd6
`define FIR_COEF_7       8'sd2
`define FIR_BASE_SHIFT   15     // Accumulator right shift at gain 0

// Frame buffer between capture and filter
`define FIFO_DEPTH       4

`endif

//--- mic_pkg.sv
`include "mic_config.svh"

package mic_pkg;

    // Sample and arithmetic widths
    typedef logic signed [`MIC_SAMPLE_BITS-1:0] mic_sample_t;   // Raw mic sample
    typedef logic signed [15:0] audio_sample_t;                 // Filtered output sample
    typedef logic signed [35:0] fir_acc_t;                      // MAC accumulator
    typedef logic [2:0] gain_t;                                 // Gain shift 0..7

    // Bit position inside one I2S frame (left and right slot)
    typedef logic [$clog2(2 * `MIC_SLOT_BITS)-1:0] i2s_bit_t;

    // One captured frame, channel 0 in the low field
    typedef struct packed {
        mic_sample_t ch3;
        mic_sample_t ch2;
        mic_sample_t ch1;
        mic_sample_t ch0;
    } mic_frame_t;

    // One filtered output frame, same channel order
    typedef struct packed {
        audio_sample_t ch3;
        audio_sample_t ch2;
        audio_sample_t ch1;
        audio_sample_t ch0;
    } audio_frame_t;

    typedef enum logic [1:0] {
        wait_left,      // Waiting for ws to fall
        shift_left,     // Taking in 24 data bits
        skip_right      // Ignoring the rest of the frame
    } capture_state_t;

    typedef enum logic [1:0] {
        idle,           // Ready for a frame
        mac,            // Walking taps and channels
        output_hold     // Result waiting for audio_ready
    } fir_state_t;

endpackage

//--- i2s_clock_gen.sv
`include "mic_config.svh"

module i2s_clock_gen import mic_pkg::*; (
    input  logic clk_in,
    input  logic rst_n,
    output logic mic_sck,       // I2S bit clock
    output logic mic_ws,        // Word select, low for the left slot
    output logic bit_strobe,    // One cycle per sck rising edge
    output logic ws_low         // Left slot flag, valid with bit_strobe
);

    localparam int HALF = `MIC_SCK_HALF;
    localparam int DW = (HALF > 1) ? $clog2(HALF) : 1;
    localparam logic [DW-1:0] DIV_LAST = DW'(HALF - 1);
    localparam i2s_bit_t RIGHT_START = i2s_bit_t'(`MIC_SLOT_BITS);

    logic [DW-1:0] div_cnt;     // clk_in cycles within a half period
    logic half_done;            // Last cycle of a half period
    i2s_bit_t bit_cnt;          // Bit clocks since the left slot began
    i2s_bit_t bit_next;

    assign half_done = (div_cnt == DIV_LAST);
    assign bit_next = bit_cnt + 1'b1;   // Wraps at 64 to start a new frame

    always_ff @(posedge clk_in or negedge rst_n) begin
        if (!rst_n) begin
            div_cnt    <= '0;
            mic_sck    <= 1'b0;
            mic_ws     <= 1'b0;
            bit_cnt    <= '0;
            bit_strobe <= 1'b0;
            ws_low     <= 1'b1;
        end else begin
            bit_strobe <= half_done && !mic_sck;    // High together with the new sck level
            if (half_done) begin
                div_cnt <= '0;
                mic_sck <= !mic_sck;
                if (!mic_sck) begin
                    ws_low <= !mic_ws;              // ws is steady at the rising edge
                end else begin
                    // Falling edge moves to the next bit and may switch the slot
                    bit_cnt <= bit_next;
                    mic_ws  <= (bit_next >= RIGHT_START);
                end
            end else begin
                div_cnt <= div_cnt + 1'b1;
            end
        end
    end

    // Strobes are one per bit period and never back to back
    a_strobe_single: assert property (@(posedge clk_in) disable iff (!rst_n)
        bit_strobe |=> !bit_strobe)
        else $error("bit_strobe high on two consecutive cycles");

endmodule

//--- i2s_capture.sv
`include "mic_config.svh"

module i2s_capture import mic_pkg::*; (
    input  logic                     clk_in,
    input  logic                     rst_n,
    input  logic [`MIC_CHANNELS-1:0] mic_data,      // One serial line per mic
    input  logic                     bit_strobe,
    input  logic                     ws_low,
    output logic                     frame_valid,
    output mic_frame_t               frame,
    input  logic                     frame_ready
);

    localparam int CH = `MIC_CHANNELS;
    localparam int SB = `MIC_SAMPLE_BITS;
    localparam int BW = $clog2(SB);
    localparam logic [BW-1:0] FIRST_BIT = BW'(SB - 1);

    capture_state_t state;
    logic [BW-1:0] bits_left;                   // Bits still to come in this slot
    mic_sample_t [CH-1:0] shreg;                // Per channel shift registers

    // Channel 0 register sits in the low frame field
    assign frame = shreg;

    always_ff @(posedge clk_in or negedge rst_n) begin
        if (!rst_n) begin
            state       <= skip_right;          // Wait for a real ws fall after reset
            bits_left   <= '0;
            frame_valid <= 1'b0;
        end else begin
            frame_valid <= 1'b0;                // Offered for one cycle only
            if (bit_strobe) begin
                case (state)
                    wait_left: begin
                        // First edge after the ws fall carries the delay bit
                        if (ws_low) begin
                            state     <= shift_left;
                            bits_left <= FIRST_BIT;
                        end
                    end
                    shift_left: begin
                        if (bits_left == '0) begin
                            state       <= skip_right;  // Bit 0 is in
                            frame_valid <= 1'b1;
                        end else begin
                            bits_left <= bits_left - 1'b1;
                        end
                    end
                    skip_right: begin
                        if (!ws_low) begin
                            state <= wait_left;         // Right slot reached
                        end
                    end
                    default: begin
                        state <= skip_right;
                    end
                endcase
            end
        end
    end

    // MSB first on every line
    always_ff @(posedge clk_in) begin
        if (bit_strobe && state == shift_left) begin
            for (int c = 0; c < CH; c++) begin
                shreg[c] <= {shreg[c][SB-2:0], mic_data[c]};
            end
        end
    end

    // One cycle pulse per frame
    a_valid_pulse: assert property (@(posedge clk_in) disable iff (!rst_n)
        frame_valid |=> !frame_valid)
        else $error("frame_valid held longer than one cycle");

endmodule

//--- sample_fifo.sv
`include "mic_config.svh"

module sample_fifo import mic_pkg::*; (
    input  logic       clk_in,
    input  logic       rst_n,
    input  logic       in_valid,
    output logic       in_ready,
    input  mic_frame_t in_frame,
    output logic       out_valid,
    input  logic       out_ready,
    output mic_frame_t out_frame,
    output logic       overrun      // Sticky until reset
);

    localparam int DEPTH = `FIFO_DEPTH;
    localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CW = $clog2(DEPTH + 1);
    localparam logic [AW-1:0] PTR_LAST = AW'(DEPTH - 1);
    localparam logic [CW-1:0] COUNT_FULL = CW'(DEPTH);

    mic_frame_t mem [DEPTH];            // Frame storage
    logic [AW-1:0] wr_ptr;
    logic [AW-1:0] rd_ptr;
    logic [CW-1:0] count;               // Frames held
    logic wr_en;
    logic rd_en;

    assign in_ready  = (count != COUNT_FULL);
    assign out_valid = (count != '0);
    assign out_frame = mem[rd_ptr];     // Head of queue, steady until popped
    assign wr_en     = in_valid && in_ready;
    assign rd_en     = out_valid && out_ready;

    always_ff @(posedge clk_in) begin
        if (wr_en) begin
            mem[wr_ptr] <= in_frame;
        end
    end

    always_ff @(posedge clk_in or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr  <= '0;
            rd_ptr  <= '0;
            count   <= '0;
            overrun <= 1'b0;
        end else begin
            if (wr_en) begin
                wr_ptr <= (wr_ptr == PTR_LAST) ? '0 : wr_ptr + 1'b1;
            end
            if (rd_en) begin
                rd_ptr <= (rd_ptr == PTR_LAST) ? '0 : rd_ptr + 1'b1;
            end
            case ({wr_en, rd_en})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;    // Idle or push and pop together
            endcase
            if (in_valid && !in_ready) begin
                overrun <= 1'b1;            // Frame lost at a full buffer
            end
        end
    end

    a_count_bound: assert property (@(posedge clk_in) disable iff (!rst_n)
        count <= COUNT_FULL)
        else $error("FIFO count above depth");

    // Head frame must not move under a stalled consumer
    a_head_stable: assert property (@(posedge clk_in) disable iff (!rst_n)
        (out_valid && !out_ready) |=> (out_valid && $stable(out_frame)))
        else $error("out_frame changed while stalled");

endmodule

//--- fir_decimator.sv
`include "mic_config.svh"

module fir_decimator import mic_pkg::*; (
    input  logic         clk_in,
    input  logic         rst_n,
    input  logic         in_valid,
    output logic         in_ready,
    input  mic_frame_t   in_frame,
    input  gain_t        gain,          // Extra left shift, 0..7
    output logic         audio_valid,
    input  logic         audio_ready,
    output audio_frame_t audio
);

    localparam int CH = `MIC_CHANNELS;
    localparam int TAPS = `FIR_TAPS;
    localparam int TW = $clog2(TAPS);
    localparam int KW = (CH > 1) ? $clog2(CH) : 1;
    localparam logic [TW-1:0] TAP_LAST = TW'(TAPS - 1);
    localparam logic [KW-1:0] CH_LAST = KW'(CH - 1);
    localparam logic signed [7:0] COEF [TAPS] = '{
        `FIR_COEF_0, `FIR_COEF_1, `FIR_COEF_2, `FIR_COEF_3,
        `FIR_COEF_4, `FIR_COEF_5, `FIR_COEF_6, `FIR_COEF_7
    };
    localparam audio_sample_t SAT_MAX = 16'sh7fff;
    localparam audio_sample_t SAT_MIN = -16'sh8000;

    fir_state_t state;
    logic phase;                        // Set after an odd frame
    logic in_fire;
    mic_sample_t hist [CH][TAPS];       // Tap 0 holds the newest sample
    mic_sample_t [CH-1:0] in_samples;
    logic [TW-1:0] tap_idx;
    logic [KW-1:0] ch_idx;
    fir_acc_t acc;                      // Running sum for the current channel
    fir_acc_t prod;
    fir_acc_t sum;
    fir_acc_t scaled;
    logic [4:0] shift_amt;
    audio_sample_t [CH-1:0] audio_q;

    // Clamp to the 16-bit range
    function automatic audio_sample_t saturate(input fir_acc_t v);
        if (v > fir_acc_t'(SAT_MAX)) begin
            return SAT_MAX;
        end
        if (v < fir_acc_t'(SAT_MIN)) begin
            return SAT_MIN;
        end
        return audio_sample_t'(v);
    endfunction

    assign in_samples  = in_frame;
    assign in_ready    = (state == idle);   // Stalls while the result waits
    assign in_fire     = in_valid && in_ready;
    assign audio_valid = (state == output_hold);
    assign audio       = audio_q;

    // Single multiplier shared by all taps and channels
    assign prod      = fir_acc_t'(hist[ch_idx][tap_idx]) * fir_acc_t'(COEF[tap_idx]);
    assign sum       = acc + prod;
    assign shift_amt = 5'(`FIR_BASE_SHIFT) - 5'(gain);  // Gain 7 leaves a shift of 8
    assign scaled    = sum >>> shift_amt;

    always_ff @(posedge clk_in or negedge rst_n) begin
        if (!rst_n) begin
            state   <= idle;
            phase   <= 1'b0;
            tap_idx <= '0;
            ch_idx  <= '0;
            for (int c = 0; c < CH; c++) begin
                for (int k = 0; k < TAPS; k++) begin
                    hist[c][k] <= '0;
                end
            end
        end else begin
            if (in_fire) begin
                for (int c = 0; c < CH; c++) begin
                    hist[c][0] <= in_samples[c];
                    for (int k = 1; k < TAPS; k++) begin
                        hist[c][k] <= hist[c][k-1];
                    end
                end
            end
            case (state)
                idle: begin
                    if (in_fire) begin
                        phase <= !phase;
                        if (phase) begin
                            state   <= mac;     // Every second frame is filtered
                            tap_idx <= '0;
                            ch_idx  <= '0;
                        end
                    end
                end
                mac: begin
                    if (tap_idx == TAP_LAST) begin
                        tap_idx <= '0;
                        ch_idx  <= ch_idx + 1'b1;
                        if (ch_idx == CH_LAST) begin
                            state <= output_hold;
                        end
                    end else begin
                        tap_idx <= tap_idx + 1'b1;
                    end
                end
                output_hold: begin
                    if (audio_ready) begin
                        state <= idle;
                    end
                end
                default: begin
                    state <= idle;
                end
            endcase
        end
    end

    // Accumulate and store each channel at its last tap
    always_ff @(posedge clk_in) begin
        if (state == idle) begin
            acc <= '0;
        end else if (state == mac) begin
            if (tap_idx == TAP_LAST) begin
                acc             <= '0;
                audio_q[ch_idx] <= saturate(scaled);
            end else begin
                acc <= sum;
            end
        end
    end

    a_audio_stable: assert property (@(posedge clk_in) disable iff (!rst_n)
        (audio_valid && !audio_ready) |=> (audio_valid && $stable(audio)))
        else $error("audio changed while stalled");

endmodule

//--- mic_array_top.sv
`include "mic_config.svh"

module mic_array_top import mic_pkg::*; (
    input  logic                     clk_in,
    input  logic                     rst_n,
    input  logic [`MIC_CHANNELS-1:0] mic_data,
    output logic                     mic_sck,
    output logic                     mic_ws,
    input  gain_t                    gain,
    output logic                     audio_valid,
    input  logic                     audio_ready,
    output audio_frame_t             audio,
    output logic                     overrun
);

    logic       bit_strobe;     // Sample point for the data lines
    logic       ws_low;
    logic       cap_valid;      // Capture to FIFO
    logic       cap_ready;
    mic_frame_t cap_frame;
    logic       buf_valid;      // FIFO to filter
    logic       buf_ready;
    mic_frame_t buf_frame;

    i2s_clock_gen i2s_clock_gen_inst (
        .clk_in     (clk_in),
        .rst_n      (rst_n),
        .mic_sck    (mic_sck),
        .mic_ws     (mic_ws),
        .bit_strobe (bit_strobe),
        .ws_low     (ws_low)
    );

    i2s_capture i2s_capture_inst (
        .clk_in      (clk_in),
        .rst_n       (rst_n),
        .mic_data    (mic_data),
        .bit_strobe  (bit_strobe),
        .ws_low      (ws_low),
        .frame_valid (cap_valid),
        .frame       (cap_frame),
        .frame_ready (cap_ready)
    );

    sample_fifo sample_fifo_inst (
        .clk_in    (clk_in),
        .rst_n     (rst_n),
        .in_valid  (cap_valid),
        .in_ready  (cap_ready),
        .in_frame  (cap_frame),
        .out_valid (buf_valid),
        .out_ready (buf_ready),
        .out_frame (buf_frame),
        .overrun   (overrun)
    );

    fir_decimator fir_decimator_inst (
        .clk_in      (clk_in),
        .rst_n       (rst_n),
        .in_valid    (buf_valid),
        .in_ready    (buf_ready),
        .in_frame    (buf_frame),
        .gain        (gain),
        .audio_valid (audio_valid),
        .audio_ready (audio_ready),
        .audio       (audio)
    );

endmodule

//--- tb_i2s_mics.sv
`include "mic_config.svh"

module tb_i2s_mics import mic_pkg::*; (
    input  logic                     clk_in,
    input  logic                     rst_n,
    input  logic                     mic_sck,
    input  logic                     mic_ws,
    input  mic_frame_t               frame_in,      // Next left-slot samples
    output logic [`MIC_CHANNELS-1:0] mic_data,
    output int                       frames_taken   // Frames latched since reset
);

    timeunit 1ns;
    timeprecision 1ps;

    logic sck_q;                    // sck seen at the previous clk_in edge
    logic ws_q;                     // ws level at the previous sck fall
    logic [5:0] pos;                // Bit position inside the current slot
    logic [5:0] pos_next;
    mic_sample_t [`MIC_CHANNELS-1:0] cur;
    logic [31:0] noise;

    // Noise source for the right slot
    function automatic logic [31:0] step_noise(input logic [31:0] x);
        return x * 32'd1664525 + 32'd1013904223;
    endfunction

    assign pos_next = pos + 1'b1;

    // Mic output changes after each sck fall, one clk_in late
    always @(posedge clk_in or negedge rst_n) begin
        if (!rst_n) begin
            sck_q        <= 1'b0;
            ws_q         <= 1'b0;
            pos          <= '0;
            cur          <= '0;
            mic_data     <= '0;
            frames_taken <= 0;
            noise        <= 32'h159d_e133;
        end else begin
            sck_q <= mic_sck;
            if (sck_q && !mic_sck) begin
                ws_q <= mic_ws;
                if (ws_q && !mic_ws) begin
                    pos          <= '0;         // Delay bit of the left slot
                    cur          <= frame_in;
                    frames_taken <= frames_taken + 1;
                    mic_data     <= '0;
                end else begin
                    pos <= pos_next;
                    if (mic_ws) begin
                        mic_data <= noise[`MIC_CHANNELS-1:0];   // Right slot is discarded
                        noise    <= step_noise(noise);
                    end else if (pos_next >= 1 && pos_next <= `MIC_SAMPLE_BITS) begin
                        for (int c = 0; c < `MIC_CHANNELS; c++) begin
                            mic_data[c] <= cur[c][`MIC_SAMPLE_BITS - pos_next];
                        end
                    end else begin
                        mic_data <= '0;                     // Tail of the left slot
                    end
                end
            end
        end
    end

endmodule

//--- tb_mic_array.sv
`include "mic_config.svh"

module tb_mic_array import mic_pkg::*;;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int FRAME_CYCLES = 2 * `MIC_SLOT_BITS * 2 * `MIC_SCK_HALF;
    localparam int TOTAL_FRAMES = 8 + 4 + 12 + 12;
    localparam real WATCHDOG_NS = (TOTAL_FRAMES + 4 * 4 + 4) * FRAME_CYCLES * 20.0;

    logic clk_in;
    logic rst_n;
    logic [`MIC_CHANNELS-1:0] mic_data;
    logic mic_sck;
    logic mic_ws;
    gain_t gain;
    logic audio_valid;
    logic audio_ready;
    audio_frame_t audio;
    logic overrun;
    mic_frame_t frame_in;
    int frames_taken;

    mic_frame_t sent [16];          // Frames of the running test
    int n_sent;
    mic_frame_t acc_q [$];          // Frames the filter really takes
    audio_frame_t exp_q [$];
    int got;                        // Output transfers seen in this phase
    logic [31:0] rnd = 32'h159d_e133;

    mic_array_top mic_array_top_inst (
        .clk_in      (clk_in),
        .rst_n       (rst_n),
        .mic_data    (mic_data),
        .mic_sck     (mic_sck),
        .mic_ws      (mic_ws),
        .gain        (gain),
        .audio_valid (audio_valid),
        .audio_ready (audio_ready),
        .audio       (audio),
        .overrun     (overrun)
    );

    tb_i2s_mics tb_i2s_mics_inst (
        .clk_in       (clk_in),
        .rst_n        (rst_n),
        .mic_sck      (mic_sck),
        .mic_ws       (mic_ws),
        .frame_in     (frame_in),
        .mic_data     (mic_data),
        .frames_taken (frames_taken)
    );

    // Silence once the phase has run out of frames
    assign frame_in = (frames_taken < n_sent) ? sent[frames_taken] : '0;

    initial begin
        clk_in = 1'b0;
        forever #10 clk_in = !clk_in;
    end

    function automatic logic [31:0] next_rand(input logic [31:0] x);
        return x * 32'd1664525 + 32'd1013904223;
    endfunction

    // Output j of the decimated FIR over the accepted frames
    // History before frame 0 counts as zero
    function automatic audio_frame_t fir_reference(input int j, input gain_t g);
        longint coef [8] = '{`FIR_COEF_0, `FIR_COEF_1, `FIR_COEF_2, `FIR_COEF_3,
                             `FIR_COEF_4, `FIR_COEF_5, `FIR_COEF_6, `FIR_COEF_7};
        audio_sample_t [`MIC_CHANNELS-1:0] res;
        mic_sample_t [`MIC_CHANNELS-1:0] s;
        longint sum;
        for (int c = 0; c < `MIC_CHANNELS; c++) begin
            sum = 0;
            for (int t = 0; t < `FIR_TAPS; t++) begin
                if (j - t >= 0) begin
                    s = acc_q[j - t];
                    sum += coef[t] * longint'(s[c]);
                end
            end
            sum = sum >>> (`FIR_BASE_SHIFT - int'(g));     // Gain lowers the shift
            if (sum > 32767) sum = 32767;           // Clamp to 16 bits
            if (sum < -32768) sum = -32768;
            res[c] = audio_sample_t'(sum);
        end
        return res;
    endfunction

    task automatic stop_with_failure();
        $display("*** TEST FAILED ***");
        $fatal(1);
    endtask

    task automatic compare_audio_frame(input audio_frame_t got_f, input audio_frame_t exp_f);
        audio_sample_t [`MIC_CHANNELS-1:0] g;
        audio_sample_t [`MIC_CHANNELS-1:0] e;
        g = got_f;
        e = exp_f;
        for (int c = 0; c < `MIC_CHANNELS; c++) begin
            if (g[c] !== e[c]) begin
                $display("Fail at %0t: channel %0d audio %0d, expected %0d",
                         $time, c, g[c], e[c]);
                stop_with_failure();
            end
        end
    endtask

    task automatic compare_overrun(input logic got_o, input logic exp_o);
        if (got_o !== exp_o) begin
            $display("Fail at %0t: overrun %b, expected %b", $time, got_o, exp_o);
            stop_with_failure();
        end
    endtask

    // Measures one period of a clock-like DUT output
    task automatic check_period(input logic which_ws, input realtime expected);
        realtime t0;
        if (which_ws) begin
            @(posedge mic_ws);
        end else begin
            @(posedge mic_sck);
        end
        t0 = $realtime;
        if (which_ws) begin
            @(posedge mic_ws);
        end else begin
            @(posedge mic_sck);
        end
        if ($realtime - t0 != expected) begin
            $display("Fail at %0t: period %0t, expected %0t",
                     $time, $realtime - t0, expected);
            stop_with_failure();
        end
    endtask

    // Kind 2 random, 3 full scale, 4 random back-pressure, 5 long stall
    task automatic run_phase(input int n, input int kind, input gain_t g);
        int run_left;
        int n_exp;
        mic_sample_t [`MIC_CHANNELS-1:0] s;
        for (int i = 0; i < n; i++) begin
            for (int c = 0; c < `MIC_CHANNELS; c++) begin
                rnd = next_rand(rnd);
                if (kind == 3) begin
                    s[c] = ((c + i) % 2 == 0) ? 24'sh7fffff : -24'sh800000;
                end else begin
                    s[c] = rnd[31:8];
                end
            end
            sent[i] = s;
        end
        acc_q.delete();
        for (int i = 0; i < n; i++) begin
            // Frames 6 and 7 arrive at a full FIFO during the stall
            if (!(kind == 5 && (i == 6 || i == 7))) begin
                acc_q.push_back(sent[i]);
            end
        end
        exp_q.delete();
        for (int j = 1; j < acc_q.size(); j += 2) begin
            exp_q.push_back(fir_reference(j, g));   // Every second frame gives an output
        end
        n_exp = exp_q.size();
        n_sent = n;
        got <= 0;
        run_left = 0;
        @(posedge clk_in);
        rst_n <= 1'b0;
        gain <= g;
        audio_ready <= (kind != 5);
        repeat (2) @(posedge clk_in);
        rst_n <= 1'b1;
        if (kind == 2) begin
            check_period(1'b0, 8 * 20.0);
            check_period(1'b1, FRAME_CYCLES * 20.0);
            // Second frame not captured yet
            if (audio_valid !== 1'b0) begin
                $display("Fail at %0t: audio_valid high before the second frame", $time);
                stop_with_failure();
            end
            compare_overrun(overrun, 1'b0);
        end
        if (kind == 5) begin
            while (!overrun) @(posedge clk_in);
            repeat (FRAME_CYCLES * 3 / 2) @(posedge clk_in);  // Past the second drop
            audio_ready <= 1'b1;
        end
        while (got < n_exp) begin
            @(posedge clk_in);
            if (kind == 4) begin
                if (run_left == 0) begin
                    rnd = next_rand(rnd);
                    if (audio_ready) begin
                        audio_ready <= 1'b0;                        // Stall up to two frames
                        run_left = rnd[31:16] % (2 * FRAME_CYCLES);
                    end else begin
                        audio_ready <= 1'b1;
                        run_left = 256 + rnd[31:16] % 256;
                    end
                end else begin
                    run_left--;
                end
            end
        end
        compare_overrun(overrun, kind == 5);
    endtask

    // Every output transfer takes the next expected frame
    always @(posedge clk_in) begin
        if (rst_n && audio_valid && audio_ready) begin
            if (exp_q.size() == 0) begin
                $display("Fail at %0t: output frame with none expected", $time);
                stop_with_failure();
            end else begin
                compare_audio_frame(audio, exp_q.pop_front());
                got <= got + 1;
            end
        end
    end

    initial begin
        #(WATCHDOG_NS);
        $display("Watchdog expired, outputs stopped arriving");
        stop_with_failure();
    end

    initial begin
        rst_n <= 1'b0;
        gain <= '0;
        audio_ready <= 1'b1;
        n_sent = 0;
        run_phase(8, 2, 3'd0);
        run_phase(4, 3, 3'd7);
        run_phase(12, 4, 3'd0);
        run_phase(12, 5, 3'd2);
        $display("*** TEST PASSED ***");
        $finish;
    end

endmodule

//--- src.f
+incdir+.
mic_pkg.sv
i2s_clock_gen.sv
i2s_capture.sv
sample_fifo.sv
fir_decimator.sv
mic_array_top.sv
tb_i2s_mics.sv
tb_mic_array.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the mic array testbench with Verilator
rm -f sim.log
verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module tb_mic_array -f src.f -o sim_mic || exit 1
./obj_dir/sim_mic > sim.log 2>&1 || true
cat sim.log
grep -q "TEST FAILED" sim.log && exit 1
grep -q "TEST PASSED" sim.log || exit 1
exit 0
